/* common/exu_pkg.sv */
/*
 * Execution unit shared definitions
 * Widths, RV32 opcodes, the ALU operation set and the structs
 * passed between decoder, ALU, commit unit and register file
 */

package exu_pkg;

    //////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////
    localparam int XLEN            = 32;
    localparam int RFIDX_WIDTH     = 5;
    localparam int MAX_DELAY_WIDTH = 4;

    //////////////////////////////////////////////////////////////
    // Major opcodes and full system encodings
    //////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [XLEN-1:0] INSTR_WFI  = 32'h1050_0073;
    localparam logic [XLEN-1:0] INSTR_MRET = 32'h3020_0073;

    // Operations the ALU knows about
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_LUI = 3'd7
    } alu_op_e;

    //////////////////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [RFIDX_WIDTH-1:0]     rs1idx;
        logic [RFIDX_WIDTH-1:0]     rs2idx;
        logic [RFIDX_WIDTH-1:0]     rdidx;
        logic                       rd_wen;
        logic                       use_imm;
        logic [XLEN-1:0]            imm;
        alu_op_e                    op;
        logic                       ilegl;
        logic                       is_wfi;
        logic                       is_mret;
        logic [MAX_DELAY_WIDTH-1:0] pc_cycle;
    } dec_info_t;

    // Register file write port
    typedef struct packed {
        logic                   ena;
        logic [RFIDX_WIDTH-1:0] rdidx;
        logic [XLEN-1:0]        wdata;
    } wbck_t;

    // Redirect request towards fetch
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] pc;
    } flush_t;

endpackage

/* files.f */
common/exu_pkg.sv
hw/decoder.sv
hw/regfile.sv
hw/alu.sv
hw/multi_counter/multi_counter.sv
hw/commit/commit_ctrl.sv
hw/exu_top.sv
tests/exu_asserts.sv
tests/exu_tb.sv

/* hw/alu.sv */
/*
 * Integer ALU
 * Operand selection plus add, sub, logic, shifts and LUI
 */

`timescale 1ns/100ps

module alu (
    input  exu_pkg::dec_info_t       dec,
    input  logic [exu_pkg::XLEN-1:0] rs1_data,
    input  logic [exu_pkg::XLEN-1:0] rs2_data,
    output logic [exu_pkg::XLEN-1:0] result
);

    logic [exu_pkg::XLEN-1:0] op2;
    logic [4:0]               shamt;

    // Immediate forms replace rs2
    assign op2   = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op2[4:0];

    always_comb begin
        case (dec.op)
            exu_pkg::ALU_ADD: result = rs1_data + op2;
            exu_pkg::ALU_SUB: result = rs1_data - op2;
            exu_pkg::ALU_AND: result = rs1_data & op2;
            exu_pkg::ALU_OR:  result = rs1_data | op2;
            exu_pkg::ALU_XOR: result = rs1_data ^ op2;
            exu_pkg::ALU_SLL: result = rs1_data << shamt;
            exu_pkg::ALU_SRL: result = rs1_data >> shamt;
            exu_pkg::ALU_LUI: result = dec.imm;
            default:          result = '0;
        endcase
    end

endmodule

/* hw/commit/commit_ctrl.sv */
/*
 * Commit unit
 * Turns each completion into a writeback, a trap, an MRET return
 * or a sleep, and holds the RUN / TRAP / SLEEP state
 */

`timescale 1ns/100ps

module commit_ctrl #(
    parameter logic [exu_pkg::XLEN-1:0] TRAP_VECTOR = 32'h0000_0100
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     ifu_valid,
    input  logic                     exu_ready,
    input  logic                     ext_irq,
    input  logic [exu_pkg::XLEN-1:0] pc,
    input  exu_pkg::dec_info_t       dec,
    input  logic [exu_pkg::XLEN-1:0] result,
    output exu_pkg::wbck_t           wbck,
    output exu_pkg::flush_t          flush,
    output logic                     excp,
    output logic                     core_wfi,
    output logic                     halt
);

    typedef enum logic [1:0] {
        ST_RUN   = 2'd0,
        ST_TRAP  = 2'd1,
        ST_SLEEP = 2'd2
    } cmt_state_e;

    cmt_state_e               state;
    cmt_state_e               pre_sleep;
    logic [exu_pkg::XLEN-1:0] epc;
    logic                     complete;
    logic                     do_trap;
    logic                     do_mret;
    logic                     do_wfi;

    assign complete = ifu_valid & exu_ready;
    assign do_trap  = complete & dec.ilegl;
    assign do_mret  = complete & dec.is_mret;
    assign do_wfi   = complete & dec.is_wfi;

    ////////////////////////////////////////////////////////////
    // Completion outputs
    ////////////////////////////////////////////////////////////
    assign wbck.ena   = complete & dec.rd_wen & ~dec.ilegl;
    assign wbck.rdidx = dec.rdidx;
    // x0 still gets a pulse with zero data
    assign wbck.wdata = (dec.rdidx == '0) ? '0 : result;

    assign flush.req = do_trap | do_mret;
    assign flush.pc  = do_trap ? TRAP_VECTOR : epc;
    assign excp      = do_trap;

    assign core_wfi = (state == ST_SLEEP);
    assign halt     = (state == ST_SLEEP);

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_RUN;
            pre_sleep <= ST_RUN;
        end else begin
            if (state == ST_SLEEP) begin
                if (ext_irq) begin
                    state <= pre_sleep;
                end
            end else if (do_trap) begin
                state <= ST_TRAP;
            end else if (do_mret) begin
                state <= ST_RUN;
            end else if (do_wfi) begin
                // Remember where to resume after the interrupt
                pre_sleep <= state;
                state     <= ST_SLEEP;
            end
        end
    end

    // Trapping pc that a nested trap overwrites
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            epc <= '0;
        end else if (do_trap) begin
            epc <= pc;
        end
    end

endmodule

/* hw/decoder.sv */
/*
 * RV32 instruction decoder
 * Extracts register indices and immediates, picks the ALU operation
 * and flags anything outside the supported subset as illegal
 */

`timescale 1ns/100ps

module decoder #(
    parameter int unsigned SHIFT_CYCLES = 4
) (
    input  logic [exu_pkg::XLEN-1:0] instr,
    output exu_pkg::dec_info_t       dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        dec          = '0;
        dec.rs1idx   = instr[19:15];
        dec.rs2idx   = instr[24:20];
        dec.rdidx    = instr[11:7];
        // I-type immediate unless LUI overrides it
        dec.imm      = {{20{instr[31]}}, instr[31:20]};
        dec.op       = exu_pkg::ALU_ADD;
        dec.ilegl    = 1'b1;

        case (opcode)
            exu_pkg::OPC_OP: begin
                dec.rd_wen = 1'b1;
                dec.ilegl  = 1'b0;
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec.op = exu_pkg::ALU_SUB;
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  dec.op = exu_pkg::ALU_ADD;
                        3'b001:  dec.op = exu_pkg::ALU_SLL;
                        3'b100:  dec.op = exu_pkg::ALU_XOR;
                        3'b101:  dec.op = exu_pkg::ALU_SRL;
                        3'b110:  dec.op = exu_pkg::ALU_OR;
                        3'b111:  dec.op = exu_pkg::ALU_AND;
                        default: dec.ilegl = 1'b1;
                    endcase
                end else begin
                    dec.ilegl = 1'b1;
                end
            end
            exu_pkg::OPC_OP_IMM: begin
                dec.rd_wen  = 1'b1;
                dec.use_imm = 1'b1;
                dec.ilegl   = 1'b0;
                case (funct3)
                    3'b000:  dec.op = exu_pkg::ALU_ADD;
                    3'b100:  dec.op = exu_pkg::ALU_XOR;
                    3'b110:  dec.op = exu_pkg::ALU_OR;
                    3'b111:  dec.op = exu_pkg::ALU_AND;
                    // SLTI, SLTIU and immediate shifts are not handled
                    default: dec.ilegl = 1'b1;
                endcase
            end
            exu_pkg::OPC_LUI: begin
                dec.rd_wen  = 1'b1;
                dec.use_imm = 1'b1;
                dec.ilegl   = 1'b0;
                dec.op      = exu_pkg::ALU_LUI;
                dec.imm     = {instr[31:12], 12'b0};
            end
            exu_pkg::OPC_SYSTEM: begin
                // Only exact WFI and MRET encodings are accepted
                dec.is_wfi  = (instr == exu_pkg::INSTR_WFI);
                dec.is_mret = (instr == exu_pkg::INSTR_MRET);
                dec.ilegl   = ~(dec.is_wfi | dec.is_mret);
            end
            default: dec.ilegl = 1'b1;
        endcase

        // Illegal instructions never write back
        if (dec.ilegl) begin
            dec.rd_wen = 1'b0;
        end

        if (!dec.ilegl && (dec.op == exu_pkg::ALU_SLL || dec.op == exu_pkg::ALU_SRL)) begin
            dec.pc_cycle = SHIFT_CYCLES[exu_pkg::MAX_DELAY_WIDTH-1:0];
        end else begin
            dec.pc_cycle = exu_pkg::MAX_DELAY_WIDTH'(1);
        end
    end

endmodule

/* hw/exu_top.sv */
/*
 * Execution unit top level
 * Decoder, register file, ALU, cycle counter and commit unit
 */

`timescale 1ns/100ps

module exu_top #(
    parameter logic [exu_pkg::XLEN-1:0] TRAP_VECTOR  = 32'h0000_0100,
    parameter int unsigned              SHIFT_CYCLES = 4
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [exu_pkg::XLEN-1:0] instr,
    input  logic [exu_pkg::XLEN-1:0] pc,
    input  logic                     ifu_valid,
    input  logic                     ext_irq,
    output logic                     exu_ready,
    output logic                     core_wfi,
    output exu_pkg::wbck_t           wbck,
    output exu_pkg::flush_t          flush,
    output logic                     excp,
    output logic                     unexpected_err
);

    exu_pkg::dec_info_t       dec;
    logic [exu_pkg::XLEN-1:0] rs1_data;
    logic [exu_pkg::XLEN-1:0] rs2_data;
    logic [exu_pkg::XLEN-1:0] result;
    logic                     halt;

    ////////////////////////////////////////////////////////////
    // Decode and operand fetch
    ////////////////////////////////////////////////////////////
    decoder #(
        .SHIFT_CYCLES (SHIFT_CYCLES)
    ) u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1idx   (dec.rs1idx),
        .rs2idx   (dec.rs2idx),
        .wbck     (wbck),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////
    alu u_alu (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (result)
    );

    multi_counter u_multi_counter (
        .clk            (clk),
        .arst_n         (arst_n),
        .ifu_valid      (ifu_valid),
        .halt           (halt),
        .pc_cycle       (dec.pc_cycle),
        .exu_ready      (exu_ready),
        .unexpected_err (unexpected_err)
    );

    ////////////////////////////////////////////////////////////
    // Commit
    ////////////////////////////////////////////////////////////
    commit_ctrl #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) u_commit_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .ifu_valid (ifu_valid),
        .exu_ready (exu_ready),
        .ext_irq   (ext_irq),
        .pc        (pc),
        .dec       (dec),
        .result    (result),
        .wbck      (wbck),
        .flush     (flush),
        .excp      (excp),
        .core_wfi  (core_wfi),
        .halt      (halt)
    );

endmodule

/* hw/multi_counter/multi_counter.sv */
/*
 * Instruction cycle counter
 * Raises ready on the last cycle of the current instruction and
 * flags an instruction withdrawn before it completed
 */

`timescale 1ns/100ps

module multi_counter (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                ifu_valid,
    input  logic                                halt,
    input  logic [exu_pkg::MAX_DELAY_WIDTH-1:0] pc_cycle,
    output logic                                exu_ready,
    output logic                                unexpected_err
);

    logic [exu_pkg::MAX_DELAY_WIDTH-1:0] count;

    // Ready on the last cycle of the instruction unless halted
    assign exu_ready = ifu_valid & ~halt & (count == pc_cycle - 1'b1);

    // Valid dropped in the middle of a multi-cycle op
    assign unexpected_err = ~ifu_valid & (count != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (halt || exu_ready || !ifu_valid) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

/* hw/regfile.sv */
/*
 * Integer register file
 * Two asynchronous read ports, one write port, x0 hardwired to zero
 */

`timescale 1ns/100ps

module regfile (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [exu_pkg::RFIDX_WIDTH-1:0] rs1idx,
    input  logic [exu_pkg::RFIDX_WIDTH-1:0] rs2idx,
    input  exu_pkg::wbck_t                  wbck,
    output logic [exu_pkg::XLEN-1:0]        rs1_data,
    output logic [exu_pkg::XLEN-1:0]        rs2_data
);

    logic [exu_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbck.ena && wbck.rdidx != '0) begin
            regs[wbck.rdidx] <= wbck.wdata;
        end
    end

    assign rs1_data = (rs1idx == '0) ? '0 : regs[rs1idx];
    assign rs2_data = (rs2idx == '0) ? '0 : regs[rs2idx];

endmodule

/* run.sh */
#!/bin/sh
# Build the execution unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exu_tb -f files.f

status=0
out=$(./obj_dir/Vexu_tb 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

/* tests/exu_asserts.sv */
/*
 * Execution unit protocol assertions
 * Bound into exu_top to watch the commit outputs every cycle
 */

`timescale 1ns/100ps

module exu_asserts #(
    parameter logic [exu_pkg::XLEN-1:0] TRAP_VECTOR = 32'h0000_0100
) (
    input logic            clk,
    input logic            arst_n,
    input logic            exu_ready,
    input logic            core_wfi,
    input logic            excp,
    input exu_pkg::wbck_t  wbck,
    input exu_pkg::flush_t flush
);

    // Number of failed checks
    int unsigned assert_errors = 0;

    // A completion is either a writeback or a redirect
    wb_flush_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(wbck.ena && flush.req))
        else begin
            $error("wbck.ena and flush.req asserted in the same cycle");
            assert_errors++;
        end

    // Sleeping core accepts nothing
    wfi_no_ready: assert property (@(posedge clk) disable iff (!arst_n)
        core_wfi |-> !exu_ready)
        else begin
            $error("exu_ready high while core_wfi is set");
            assert_errors++;
        end

    excp_to_vector: assert property (@(posedge clk) disable iff (!arst_n)
        excp |-> (flush.req && flush.pc == TRAP_VECTOR))
        else begin
            $error("excp without a flush to the trap vector");
            assert_errors++;
        end

endmodule

bind exu_top exu_asserts #(
    .TRAP_VECTOR (TRAP_VECTOR)
) exu_asserts_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .exu_ready (exu_ready),
    .core_wfi  (core_wfi),
    .excp      (excp),
    .wbck      (wbck),
    .flush     (flush)
);

/* tests/exu_tb.sv */
/*
 * Execution unit testbench
 * Directed tests for ALU ops, shifts, traps, MRET, WFI and a
 * withdrawn instruction, checked against a register file model
 */

`timescale 1ns/100ps

module exu_tb;

    localparam int                 CLK_PERIOD   = 40;
    localparam int unsigned        SHIFT_CYCLES = 4;
    localparam logic [31:0]        TRAP_VECTOR  = 32'h0000_0100;
    localparam int                 MAX_WAIT     = SHIFT_CYCLES + 4;
    // Upper bound on instructions issued over all tests
    localparam int                 NUM_INSTR    = 40;
    localparam int                 TIMEOUT_NS   = (NUM_INSTR * MAX_WAIT + 20) * CLK_PERIOD;

    logic            clk;
    logic            arst_n;
    logic [31:0]     instr;
    logic [31:0]     pc;
    logic            ifu_valid;
    logic            ext_irq;
    logic            exu_ready;
    logic            core_wfi;
    exu_pkg::wbck_t  wbck;
    exu_pkg::flush_t flush;
    logic            excp;
    logic            unexpected_err;

    logic [31:0]     ref_rf [0:31];
    logic [31:0]     seed;
    logic [31:0]     cur_pc;
    int              errors;
    int              got_cycles;
    exu_pkg::wbck_t  got_wbck;
    exu_pkg::flush_t got_flush;
    logic            got_excp;

    exu_top #(
        .TRAP_VECTOR  (TRAP_VECTOR),
        .SHIFT_CYCLES (SHIFT_CYCLES)
    ) exu_top_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr          (instr),
        .pc             (pc),
        .ifu_valid      (ifu_valid),
        .ext_irq        (ext_irq),
        .exu_ready      (exu_ready),
        .core_wfi       (core_wfi),
        .wbck           (wbck),
        .flush          (flush),
        .excp           (excp),
        .unexpected_err (unexpected_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, exu_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, exu_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Sample the outputs in the completion cycle before dropping valid
    task automatic wait_done(input int max_cycles);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < max_cycles) begin
            @(negedge clk);
            n++;
            if (exu_ready) begin
                done      = 1'b1;
                got_wbck  = wbck;
                got_flush = flush;
                got_excp  = excp;
            end else begin
                check("wbck.ena", 32'(wbck.ena), 32'd0);
                @(posedge clk);
                #2;
            end
        end
        if (!done) begin
            $display("ERROR: no exu_ready within %0d cycles for instr %h", max_cycles, instr);
            errors++;
        end
        got_cycles = n;
        @(posedge clk);
        #2;
        ifu_valid = 1'b0;
    endtask

    task automatic issue(input logic [31:0] ins);
        instr     = ins;
        pc        = cur_pc;
        ifu_valid = 1'b1;
        cur_pc    = cur_pc + 32'd4;
        wait_done(MAX_WAIT);
    endtask

    task automatic check_wb(input logic [4:0] rd, input logic [31:0] exp_val,
                            input int exp_cycles);
        logic [31:0] exp_w;
        exp_w = (rd == 5'd0) ? 32'd0 : exp_val;
        check("cycles", got_cycles, exp_cycles);
        check("wbck.ena", 32'(got_wbck.ena), 32'd1);
        check("wbck.rdidx", 32'(got_wbck.rdidx), 32'(rd));
        check("wbck.wdata", got_wbck.wdata, exp_w);
        check("flush.req", 32'(got_flush.req), 32'd0);
        check("excp", 32'(got_excp), 32'd0);
        ref_rf[rd] = exp_w;
    endtask

    task automatic run_alu(input logic [31:0] ins, input logic [4:0] rd,
                           input logic [31:0] exp_val, input int exp_cycles);
        issue(ins);
        check_wb(rd, exp_val, exp_cycles);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_and_alu();
        logic [31:0] r;
        logic [4:0]  rd;
        @(negedge clk);
        check("exu_ready", 32'(exu_ready), 32'd0);
        check("wbck.ena", 32'(wbck.ena), 32'd0);
        check("flush.req", 32'(flush.req), 32'd0);
        check("excp", 32'(excp), 32'd0);
        check("core_wfi", 32'(core_wfi), 32'd0);
        check("unexpected_err", 32'(unexpected_err), 32'd0);
        @(posedge clk);
        #2;
        for (int i = 1; i <= 6; i++) begin
            rd = 5'(i);
            r  = next_rand();
            run_alu({r[31:12], rd, exu_pkg::OPC_LUI}, rd, {r[31:12], 12'b0}, 1);
            r  = next_rand();
            run_alu(enc_i(3'b000, rd, rd, r[11:0]), rd, ref_rf[rd] + sext12(r[11:0]), 1);
        end
        run_alu(enc_r(7'h00, 3'b000, 5'd7, 5'd1, 5'd2), 5'd7, ref_rf[1] + ref_rf[2], 1);
        run_alu(enc_r(7'h20, 3'b000, 5'd8, 5'd3, 5'd4), 5'd8, ref_rf[3] - ref_rf[4], 1);
        run_alu(enc_r(7'h00, 3'b111, 5'd9, 5'd5, 5'd6), 5'd9, ref_rf[5] & ref_rf[6], 1);
        run_alu(enc_r(7'h00, 3'b110, 5'd10, 5'd1, 5'd3), 5'd10, ref_rf[1] | ref_rf[3], 1);
        run_alu(enc_r(7'h00, 3'b100, 5'd11, 5'd2, 5'd6), 5'd11, ref_rf[2] ^ ref_rf[6], 1);
        r = next_rand();
        run_alu(enc_i(3'b111, 5'd12, 5'd7, r[11:0]), 5'd12, ref_rf[7] & sext12(r[11:0]), 1);
        run_alu(enc_i(3'b110, 5'd13, 5'd8, r[23:12]), 5'd13, ref_rf[8] | sext12(r[23:12]), 1);
        run_alu(enc_i(3'b100, 5'd14, 5'd9, r[31:20]), 5'd14, ref_rf[9] ^ sext12(r[31:20]), 1);
    endtask

    task automatic test_shifts();
        run_alu(enc_r(7'h00, 3'b001, 5'd15, 5'd1, 5'd2), 5'd15,
                ref_rf[1] << ref_rf[2][4:0], SHIFT_CYCLES);
        run_alu(enc_r(7'h00, 3'b101, 5'd16, 5'd9, 5'd3), 5'd16,
                ref_rf[9] >> ref_rf[3][4:0], SHIFT_CYCLES);
        // Write to x0 and read it back through an ADD
        run_alu(enc_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd2), 5'd0, 32'd0, 1);
        run_alu(enc_r(7'h00, 3'b000, 5'd17, 5'd0, 5'd4), 5'd17, ref_rf[4], 1);
    endtask

    task automatic trap_once(input logic [31:0] ins);
        issue(ins);
        check("cycles", got_cycles, 1);
        check("wbck.ena", 32'(got_wbck.ena), 32'd0);
        check("flush.req", 32'(got_flush.req), 32'd1);
        check("flush.pc", got_flush.pc, TRAP_VECTOR);
        check("excp", 32'(got_excp), 32'd1);
    endtask

    task automatic test_trap_mret();
        logic [31:0] trap_pc;
        trap_once(32'hffff_ffff);
        // Nested trap inside the handler moves epc
        trap_pc = cur_pc;
        trap_once(enc_r(7'h01, 3'b000, 5'd3, 5'd1, 5'd2));
        issue(exu_pkg::INSTR_MRET);
        check("cycles", got_cycles, 1);
        check("wbck.ena", 32'(got_wbck.ena), 32'd0);
        check("flush.req", 32'(got_flush.req), 32'd1);
        check("flush.pc", got_flush.pc, trap_pc);
        check("excp", 32'(got_excp), 32'd0);
    endtask

    task automatic test_wfi();
        issue(exu_pkg::INSTR_WFI);
        check("cycles", got_cycles, 1);
        check("wbck.ena", 32'(got_wbck.ena), 32'd0);
        check("flush.req", 32'(got_flush.req), 32'd0);
        check("excp", 32'(got_excp), 32'd0);
        instr     = enc_r(7'h00, 3'b000, 5'd19, 5'd1, 5'd5);
        pc        = cur_pc;
        ifu_valid = 1'b1;
        cur_pc    = cur_pc + 32'd4;
        repeat (3) begin
            @(negedge clk);
            check("core_wfi", 32'(core_wfi), 32'd1);
            check("exu_ready", 32'(exu_ready), 32'd0);
            @(posedge clk);
            #2;
        end
        ext_irq = 1'b1;
        @(posedge clk);
        #2;
        check("core_wfi", 32'(core_wfi), 32'd0);
        ext_irq = 1'b0;
        wait_done(MAX_WAIT);
        check_wb(5'd19, ref_rf[1] + ref_rf[5], 1);
    endtask

    task automatic test_withdraw();
        instr     = enc_r(7'h00, 3'b001, 5'd20, 5'd1, 5'd2);
        pc        = cur_pc;
        ifu_valid = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check("exu_ready", 32'(exu_ready), 32'd0);
            check("unexpected_err", 32'(unexpected_err), 32'd0);
            @(posedge clk);
            #2;
        end
        ifu_valid = 1'b0;
        @(negedge clk);
        if (unexpected_err !== 1'b1) begin
            $display("ERROR: unexpected_err did not pulse after valid was withdrawn");
            errors++;
        end
        @(posedge clk);
        #2;
        run_alu(enc_r(7'h00, 3'b101, 5'd20, 5'd10, 5'd4), 5'd20,
                ref_rf[10] >> ref_rf[4][4:0], SHIFT_CYCLES);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        arst_n    = 1'b0;
        instr     = 32'd0;
        pc        = 32'd0;
        ifu_valid = 1'b0;
        ext_irq   = 1'b0;
        seed      = 32'hab1a_ea14;
        cur_pc    = 32'h0000_1000;
        errors    = 0;
        ref_rf    = '{default: 32'd0};
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        test_reset_and_alu();
        test_shifts();
        test_trap_mret();
        test_wfi();
        test_withdraw();

        errors += exu_top_i.exu_asserts_i.assert_errors;
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
